//--- rv_backend_pkg.sv
package rv_backend_pkg;

	// widths fixed by the ISA
	typedef logic [63:0] xlen_t;
	typedef logic [63:0] pc_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  byte_mask_t;   // one bit per byte of a doubleword
	typedef logic [63:0] mem_addr_t;    // bits 10..3 index, 2..0 pick the lane

	// operation kind from execute
	typedef logic [1:0] op_kind_t;
	localparam op_kind_t KIND_ALU   = 2'd0;   // write alu result to rd
	localparam op_kind_t KIND_LOAD  = 2'd1;   // read memory, write rd
	localparam op_kind_t KIND_STORE = 2'd2;   // write memory only

	// access size, log2 of the byte count
	typedef logic [1:0] acc_size_t;
	localparam acc_size_t SIZE_B = 2'd0;
	localparam acc_size_t SIZE_H = 2'd1;
	localparam acc_size_t SIZE_W = 2'd2;
	localparam acc_size_t SIZE_D = 2'd3;

	// data memory geometry
	localparam int MEM_DEPTH   = 256;   // doublewords
	localparam int MEM_AW      = $clog2(MEM_DEPTH);
	localparam int MAX_MEM_LAT = 4;     // cycles from request to response
	localparam int LAT_W       = $clog2(MAX_MEM_LAT);

	// retire pc seen right after reset
	localparam pc_t RESET_PC = 64'h8000_0000;

endpackage

//--- mem_wb_if.sv
`timescale 1ns/1ps

// completed op travelling from mem stage to writeback
interface mem_wb_if;
	logic                      valid;
	rv_backend_pkg::op_kind_t  kind;
	rv_backend_pkg::acc_size_t size;
	logic                      is_unsigned;
	rv_backend_pkg::reg_addr_t rd;
	rv_backend_pkg::xlen_t     alu_res;     // also the access address
	rv_backend_pkg::xlen_t     load_data;   // raw doubleword, not yet extended
	rv_backend_pkg::pc_t       pc;
	logic                      ebreak;

	modport mem_src (
		output valid, kind, size, is_unsigned, rd, alu_res, load_data, pc, ebreak
	);

	modport wb_dst (
		input valid, kind, size, is_unsigned, rd, alu_res, load_data, pc, ebreak
	);
endinterface

//--- data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       req_valid_i,
	input  logic                       req_write_i,
	input  rv_backend_pkg::mem_addr_t  req_addr_i,
	input  rv_backend_pkg::xlen_t      req_wdata_i,
	input  rv_backend_pkg::byte_mask_t req_mask_i,
	output logic                       rsp_valid_o,
	output rv_backend_pkg::xlen_t      rsp_rdata_o
);

	rv_backend_pkg::xlen_t mem_q [rv_backend_pkg::MEM_DEPTH] = '{default: '0};

	logic [rv_backend_pkg::MEM_AW-1:0] req_idx;
	logic [rv_backend_pkg::MEM_AW-1:0] idx_q;   // index of the access in flight
	logic [rv_backend_pkg::LAT_W-1:0]  lat_cnt_q;
	logic                              busy_q;
	logic [7:0]                        lfsr_q;
	logic                              lfsr_fb;

	assign req_idx = req_addr_i[rv_backend_pkg::MEM_AW+2:3];
	assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

	// free running lfsr, low bits give the next latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= 8'ha5;
		end else begin
			lfsr_q <= {lfsr_q[6:0], lfsr_fb};
		end
	end

	// latency countdown and response pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q      <= 1'b0;
			lat_cnt_q   <= '0;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= 1'b0;
			if (req_valid_i) begin
				busy_q    <= 1'b1;
				lat_cnt_q <= lfsr_q[rv_backend_pkg::LAT_W-1:0];   // 0..3 extra cycles
			end else if (busy_q) begin
				if (lat_cnt_q == '0) begin
					busy_q      <= 1'b0;
					rsp_valid_o <= 1'b1;
				end else begin
					lat_cnt_q <= lat_cnt_q - 1'b1;
				end
			end
		end
	end

	// array access, write lands when the request is seen
	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			idx_q <= req_idx;
			if (req_write_i) begin
				for (int i = 0; i < 8; i++) begin
					if (req_mask_i[i]) begin
						mem_q[req_idx][8*i +: 8] <= req_wdata_i[8*i +: 8];
					end
				end
			end
		end
		if (busy_q && lat_cnt_q == '0) begin
			rsp_rdata_o <= mem_q[idx_q];   // sampled as the response fires
		end
	end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       op_valid_i,
	output logic                       op_ready_o,
	input  rv_backend_pkg::op_kind_t   op_kind_i,
	input  rv_backend_pkg::acc_size_t  op_size_i,
	input  logic                       op_unsigned_i,
	input  rv_backend_pkg::reg_addr_t  op_rd_i,
	input  rv_backend_pkg::xlen_t      op_alu_res_i,
	input  rv_backend_pkg::xlen_t      op_store_data_i,
	input  rv_backend_pkg::pc_t        op_pc_i,
	input  logic                       op_ebreak_i,
	output logic                       req_valid_o,
	output logic                       req_write_o,
	output rv_backend_pkg::mem_addr_t  req_addr_o,
	output rv_backend_pkg::xlen_t      req_wdata_o,
	output rv_backend_pkg::byte_mask_t req_mask_o,
	input  logic                       rsp_valid_i,
	input  rv_backend_pkg::xlen_t      rsp_rdata_i,
	mem_wb_if.mem_src                  wb
);

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

	state_t state_q;
	logic   accept;
	logic   alu_pend_q;   // alu op latched last cycle
	logic   mem_done;

	// latched operation
	rv_backend_pkg::op_kind_t  kind_q;
	rv_backend_pkg::acc_size_t size_q;
	logic                      uns_q;
	rv_backend_pkg::reg_addr_t rd_q;
	rv_backend_pkg::xlen_t     alu_res_q;
	rv_backend_pkg::xlen_t     store_data_q;
	rv_backend_pkg::pc_t       pc_q;
	logic                      ebreak_q;

	rv_backend_pkg::byte_mask_t size_mask;
	logic [5:0]                 lane_shift;

	assign op_ready_o = (state_q == IDLE);
	assign accept     = op_valid_i && op_ready_o;
	assign mem_done   = (state_q == WAIT) && rsp_valid_i;
	assign lane_shift = {alu_res_q[2:0], 3'b000};

	always_comb begin
		case (size_q)
			rv_backend_pkg::SIZE_B: size_mask = 8'h01;
			rv_backend_pkg::SIZE_H: size_mask = 8'h03;
			rv_backend_pkg::SIZE_W: size_mask = 8'h0f;
			default:                size_mask = 8'hff;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= IDLE;
			alu_pend_q  <= 1'b0;
			req_valid_o <= 1'b0;
			wb.valid    <= 1'b0;
		end else begin
			alu_pend_q  <= accept && (op_kind_i == rv_backend_pkg::KIND_ALU);
			req_valid_o <= (state_q == ISSUE);   // single cycle request
			wb.valid    <= alu_pend_q || mem_done;
			case (state_q)
				IDLE: begin
					if (accept && op_kind_i != rv_backend_pkg::KIND_ALU) begin
						state_q <= ISSUE;
					end
				end
				ISSUE: state_q <= WAIT;
				WAIT: begin
					if (rsp_valid_i) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// op latch, request payload and outgoing fields
	always_ff @(posedge clk) begin
		if (accept) begin
			kind_q       <= op_kind_i;
			size_q       <= op_size_i;
			uns_q        <= op_unsigned_i;
			rd_q         <= op_rd_i;
			alu_res_q    <= op_alu_res_i;
			store_data_q <= op_store_data_i;
			pc_q         <= op_pc_i;
			ebreak_q     <= op_ebreak_i;
		end
		if (state_q == ISSUE) begin
			req_write_o <= (kind_q == rv_backend_pkg::KIND_STORE);
			req_addr_o  <= alu_res_q;
			req_wdata_o <= store_data_q << lane_shift;   // move into byte lane
			req_mask_o  <= size_mask << alu_res_q[2:0];
		end
		if (alu_pend_q || mem_done) begin
			wb.kind        <= kind_q;
			wb.size        <= size_q;
			wb.is_unsigned <= uns_q;
			wb.rd          <= rd_q;
			wb.alu_res     <= alu_res_q;
			wb.pc          <= pc_q;
			wb.ebreak      <= ebreak_q;
			wb.load_data   <= rsp_rdata_i;   // only meaningful for loads
		end
	end

endmodule

//--- mem_wb_regs.sv
`timescale 1ns/1ps

module mem_wb_regs (
	input  logic      clk,
	input  logic      rst_n,
	mem_wb_if.wb_dst  wb_in,
	mem_wb_if.mem_src wb_out
);

	// valid follows the input every cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_out.valid <= 1'b0;
		end else begin
			wb_out.valid <= wb_in.valid;
		end
	end

	// fields hold their last value between ops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_out.kind        <= rv_backend_pkg::KIND_ALU;
			wb_out.size        <= rv_backend_pkg::SIZE_B;
			wb_out.is_unsigned <= 1'b0;
			wb_out.rd          <= '0;
			wb_out.alu_res     <= '0;
			wb_out.load_data   <= '0;
			wb_out.pc          <= rv_backend_pkg::RESET_PC;
			wb_out.ebreak      <= 1'b0;
		end else if (wb_in.valid) begin
			wb_out.kind        <= wb_in.kind;
			wb_out.size        <= wb_in.size;
			wb_out.is_unsigned <= wb_in.is_unsigned;
			wb_out.rd          <= wb_in.rd;
			wb_out.alu_res     <= wb_in.alu_res;
			wb_out.load_data   <= wb_in.load_data;
			wb_out.pc          <= wb_in.pc;
			wb_out.ebreak      <= wb_in.ebreak;
		end
	end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
	mem_wb_if.wb_dst                  wb,
	output logic                      rf_wen_o,
	output rv_backend_pkg::reg_addr_t rf_waddr_o,
	output rv_backend_pkg::xlen_t     rf_wdata_o,
	output logic                      retire_valid_o,
	output rv_backend_pkg::pc_t       retire_pc_o,
	output logic                      retire_ebreak_o
);

	rv_backend_pkg::xlen_t lane;
	rv_backend_pkg::xlen_t load_ext;

	// bring the addressed bytes down to bit 0
	assign lane = wb.load_data >> {wb.alu_res[2:0], 3'b000};

	always_comb begin
		case (wb.size)
			rv_backend_pkg::SIZE_B: load_ext = wb.is_unsigned ? {56'd0, lane[7:0]}
			                                                  : {{56{lane[7]}}, lane[7:0]};
			rv_backend_pkg::SIZE_H: load_ext = wb.is_unsigned ? {48'd0, lane[15:0]}
			                                                  : {{48{lane[15]}}, lane[15:0]};
			rv_backend_pkg::SIZE_W: load_ext = wb.is_unsigned ? {32'd0, lane[31:0]}
			                                                  : {{32{lane[31]}}, lane[31:0]};
			default:                load_ext = lane;   // doubleword, nothing to extend
		endcase
	end

	assign rf_wen_o   = wb.valid && (wb.kind != rv_backend_pkg::KIND_STORE);
	assign rf_waddr_o = wb.rd;
	assign rf_wdata_o = (wb.kind == rv_backend_pkg::KIND_LOAD) ? load_ext : wb.alu_res;

	// every valid op retires here, stores included
	assign retire_valid_o  = wb.valid;
	assign retire_pc_o     = wb.pc;
	assign retire_ebreak_o = wb.ebreak;

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wen_i,
	input  rv_backend_pkg::reg_addr_t waddr_i,
	input  rv_backend_pkg::xlen_t     wdata_i,
	input  rv_backend_pkg::reg_addr_t raddr_i,
	output rv_backend_pkg::xlen_t     rdata_o
);

	// x1..x31, x0 has no storage
	rv_backend_pkg::xlen_t regs_q [31:1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin   // writes to x0 dropped
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// combinational read for decode
	assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

//--- rv_backend_top.sv
`timescale 1ns/1ps

module rv_backend_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      op_valid_i,
	output logic                      op_ready_o,
	input  rv_backend_pkg::op_kind_t  op_kind_i,
	input  rv_backend_pkg::acc_size_t op_size_i,
	input  logic                      op_unsigned_i,
	input  rv_backend_pkg::reg_addr_t op_rd_i,
	input  rv_backend_pkg::xlen_t     op_alu_res_i,
	input  rv_backend_pkg::xlen_t     op_store_data_i,
	input  rv_backend_pkg::pc_t       op_pc_i,
	input  logic                      op_ebreak_i,
	input  rv_backend_pkg::reg_addr_t rf_raddr_i,
	output rv_backend_pkg::xlen_t     rf_rdata_o,
	output logic                      retire_valid_o,
	output rv_backend_pkg::pc_t       retire_pc_o,
	output logic                      retire_ebreak_o
);

	// memory request channel
	logic                       req_valid;
	logic                       req_write;
	rv_backend_pkg::mem_addr_t  req_addr;
	rv_backend_pkg::xlen_t      req_wdata;
	rv_backend_pkg::byte_mask_t req_mask;
	logic                       rsp_valid;
	rv_backend_pkg::xlen_t      rsp_rdata;

	// register file write port
	logic                      rf_wen;
	rv_backend_pkg::reg_addr_t rf_waddr;
	rv_backend_pkg::xlen_t     rf_wdata;

	mem_wb_if mem_to_regs ();   // mem stage -> pipeline register
	mem_wb_if regs_to_wb ();    // pipeline register -> writeback

	mem_stage mem_stage_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.op_valid_i      (op_valid_i),
		.op_ready_o      (op_ready_o),
		.op_kind_i       (op_kind_i),
		.op_size_i       (op_size_i),
		.op_unsigned_i   (op_unsigned_i),
		.op_rd_i         (op_rd_i),
		.op_alu_res_i    (op_alu_res_i),
		.op_store_data_i (op_store_data_i),
		.op_pc_i         (op_pc_i),
		.op_ebreak_i     (op_ebreak_i),
		.req_valid_o     (req_valid),
		.req_write_o     (req_write),
		.req_addr_o      (req_addr),
		.req_wdata_o     (req_wdata),
		.req_mask_o      (req_mask),
		.rsp_valid_i     (rsp_valid),
		.rsp_rdata_i     (rsp_rdata),
		.wb              (mem_to_regs.mem_src)
	);

	data_mem data_mem_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid),
		.req_write_i (req_write),
		.req_addr_i  (req_addr),
		.req_wdata_i (req_wdata),
		.req_mask_i  (req_mask),
		.rsp_valid_o (rsp_valid),
		.rsp_rdata_o (rsp_rdata)
	);

	mem_wb_regs mem_wb_regs_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_in  (mem_to_regs.wb_dst),
		.wb_out (regs_to_wb.mem_src)
	);

	wb_stage wb_stage_i (
		.wb              (regs_to_wb.wb_dst),
		.rf_wen_o        (rf_wen),
		.rf_waddr_o      (rf_waddr),
		.rf_wdata_o      (rf_wdata),
		.retire_valid_o  (retire_valid_o),
		.retire_pc_o     (retire_pc_o),
		.retire_ebreak_o (retire_ebreak_o)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wen_i   (rf_wen),
		.waddr_i (rf_waddr),
		.wdata_i (rf_wdata),
		.raddr_i (rf_raddr_i),
		.rdata_o (rf_rdata_o)
	);

endmodule

//--- tb_rv_backend.sv
`timescale 1ns/1ps

module tb_rv_backend;

	localparam int N_ALU   = 40;
	localparam int N_MEM   = 24 * 4;   // 24 stores, 48 loads back, 24 doubleword reads
	localparam int N_MIX   = 60;
	localparam int N_EBRK  = 30;
	localparam int TIMEOUT = (N_ALU + N_MEM + N_MIX + N_EBRK)
	                         * (rv_backend_pkg::MAX_MEM_LAT + 4) + 200;

	logic                      clk = 1'b0;
	logic                      rst_n, op_valid_i, op_ready_o, op_unsigned_i, op_ebreak_i;
	rv_backend_pkg::op_kind_t  op_kind_i;
	rv_backend_pkg::acc_size_t op_size_i;
	rv_backend_pkg::reg_addr_t op_rd_i, rf_raddr_i;
	rv_backend_pkg::xlen_t     op_alu_res_i, op_store_data_i, rf_rdata_o;
	rv_backend_pkg::pc_t       op_pc_i, retire_pc_o;
	logic                      retire_valid_o, retire_ebreak_o;

	// reference model state
	rv_backend_pkg::xlen_t     model_regs [32];
	logic [7:0]                mem_img [2048];   // byte image of the 256 doublewords
	rv_backend_pkg::pc_t       exp_pc_q [$];
	logic                      exp_eb_q [$];
	rv_backend_pkg::mem_addr_t addr_list [24];
	rv_backend_pkg::pc_t       next_pc = 64'h8000_1000;
	integer                    seed = 32'hf8bf;
	int                        cycles = 0, checks_ok = 0, errors = 0, accepted = 0, retired = 0;

	rv_backend_top rv_backend_top_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: operations still outstanding after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic rv_backend_pkg::xlen_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic rv_backend_pkg::mem_addr_t rand_addr(rv_backend_pkg::acc_size_t sz);
		logic [10:0] off;
		off = $random(seed);
		off = off & ~((11'd1 << sz) - 11'd1);   // aligned to the access size
		return 64'h1000_0000 | off;
	endfunction

	// little endian read of 1 << sz bytes, then extension
	function automatic rv_backend_pkg::xlen_t model_load(rv_backend_pkg::mem_addr_t a,
			rv_backend_pkg::acc_size_t sz, logic uns);
		rv_backend_pkg::xlen_t v;
		int n;
		n = 1 << sz;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = mem_img[a[10:0] + i];
		end
		if (!uns && v[8*n-1]) begin
			v = v | ~((64'd1 << (8*n)) - 64'd1);
		end
		return v;
	endfunction

	task automatic check_flag(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end else begin
			checks_ok++;
		end
	endtask

	// starts and ends on a falling edge
	task automatic check_reg(rv_backend_pkg::reg_addr_t r, rv_backend_pkg::xlen_t exp);
		rf_raddr_i = r;
		#1;
		if (rf_rdata_o !== exp) begin
			$display("Mismatch at %0t: x%0d is %h, expected %h", $time, r, rf_rdata_o, exp);
			errors++;
		end else begin
			checks_ok++;
		end
		@(negedge clk);
	endtask

	task automatic check_retire(rv_backend_pkg::pc_t exp_pc, logic exp_eb);
		if (retire_pc_o !== exp_pc || retire_ebreak_o !== exp_eb) begin
			$display("Mismatch at %0t: retired pc %h ebreak %b, expected pc %h ebreak %b",
				$time, retire_pc_o, retire_ebreak_o, exp_pc, exp_eb);
			errors++;
		end else begin
			checks_ok++;
		end
	endtask

	task automatic check_all_regs();
		for (int r = 0; r < 32; r++) begin
			check_reg(r, model_regs[r]);
		end
	endtask

	// retire monitor, one op per cycle with retire_valid_o high
	always @(negedge clk) begin
		if (rst_n && retire_valid_o) begin
			retired++;
			if (exp_pc_q.size() == 0) begin
				$display("unexpected retire of pc %h with no operation outstanding", retire_pc_o);
				errors++;
			end else begin
				check_retire(exp_pc_q.pop_front(), exp_eb_q.pop_front());
			end
		end
	end

	// entered on a falling edge, holds the fields until the op is taken
	task automatic send_op(rv_backend_pkg::op_kind_t kind, rv_backend_pkg::acc_size_t sz,
			logic uns, rv_backend_pkg::reg_addr_t rd, rv_backend_pkg::xlen_t res,
			rv_backend_pkg::xlen_t sdata, logic eb);
		op_valid_i      = 1'b1;
		op_kind_i       = kind;
		op_size_i       = sz;
		op_unsigned_i   = uns;
		op_rd_i         = rd;
		op_alu_res_i    = res;
		op_store_data_i = sdata;
		op_pc_i         = next_pc;
		op_ebreak_i     = eb;
		while (!op_ready_o) begin
			@(negedge clk);
		end
		@(posedge clk);   // transfer edge
		accepted++;
		exp_pc_q.push_back(next_pc);
		exp_eb_q.push_back(eb);
		next_pc += 4;
		if (kind == rv_backend_pkg::KIND_STORE) begin
			for (int i = 0; i < (1 << sz); i++) begin
				mem_img[res[10:0] + i] = sdata[8*i +: 8];
			end
		end else if (rd != '0) begin
			model_regs[rd] = (kind == rv_backend_pkg::KIND_LOAD) ? model_load(res, sz, uns) : res;
		end
		@(negedge clk);
		op_valid_i = 1'b0;
	endtask

	task automatic random_op(logic with_eb);
		int pick;
		rv_backend_pkg::acc_size_t sz;
		rv_backend_pkg::op_kind_t kind;
		pick = $unsigned($random(seed)) % 4;
		sz   = $random(seed);
		kind = (pick < 2) ? rv_backend_pkg::KIND_ALU
		     : (pick == 2) ? rv_backend_pkg::KIND_LOAD : rv_backend_pkg::KIND_STORE;
		if ($unsigned($random(seed)) % 4 == 0) begin
			@(negedge clk);   // idle cycle with valid low
		end
		send_op(kind, sz, $random(seed), $random(seed),
			(pick < 2) ? rand_word() : rand_addr(sz), rand_word(),
			with_eb && ($unsigned($random(seed)) % 4 == 0));
	endtask

	task automatic drain();
		while (exp_pc_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);   // last register write lands
	endtask

	task automatic report_test(string name, int mark);
		$display("test %s: %s", name, (errors == mark) ? "ok" : "errors seen");
	endtask

	initial begin
		int mark;
		int acc0;
		int ret0;
		rst_n = 1'b0;
		op_valid_i = 1'b0;
		op_kind_i = rv_backend_pkg::KIND_ALU;
		op_size_i = rv_backend_pkg::SIZE_B;
		op_unsigned_i = 1'b0;
		op_rd_i = '0;
		op_alu_res_i = '0;
		op_store_data_i = '0;
		op_pc_i = '0;
		op_ebreak_i = 1'b0;
		rf_raddr_i = '0;
		foreach (mem_img[i]) mem_img[i] = 8'h00;
		foreach (model_regs[i]) model_regs[i] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		mark = errors;
		check_flag("op_ready_o", op_ready_o, 1'b1);
		check_flag("retire_valid_o", retire_valid_o, 1'b0);
		check_retire(rv_backend_pkg::RESET_PC, 1'b0);
		check_all_regs();
		report_test("reset state", mark);

		mark = errors;
		for (int i = 0; i < N_ALU; i++) begin
			send_op(rv_backend_pkg::KIND_ALU, rv_backend_pkg::SIZE_D, 1'b0,
				(i == 7) ? 5'd0 : 5'($random(seed)), rand_word(), '0, 1'b0);   // one x0 write
		end
		drain();
		check_all_regs();
		report_test("alu writes", mark);

		mark = errors;
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 6; k++) begin
				addr_list[6*s+k] = rand_addr(s);
				send_op(rv_backend_pkg::KIND_STORE, s, 1'b0, '0, addr_list[6*s+k], rand_word(), 1'b0);
			end
			for (int k = 0; k < 6; k++) begin
				send_op(rv_backend_pkg::KIND_LOAD, s, 1'b0, 2*k+1, addr_list[6*s+k], '0, 1'b0);
				send_op(rv_backend_pkg::KIND_LOAD, s, 1'b1, 2*k+2, addr_list[6*s+k], '0, 1'b0);
			end
			drain();
			for (int k = 1; k <= 12; k++) begin
				check_reg(k, model_regs[k]);
			end
		end
		// whole doublewords expose bytes written outside the mask
		for (int k = 0; k < 24; k++) begin
			send_op(rv_backend_pkg::KIND_LOAD, rv_backend_pkg::SIZE_D, 1'b0, 8 + k,
				addr_list[k] & ~64'd7, '0, 1'b0);
		end
		drain();
		check_all_regs();
		report_test("stores and loads", mark);

		mark = errors;
		acc0 = accepted;
		ret0 = retired;
		for (int i = 0; i < N_MIX; i++) begin
			random_op(1'b0);
		end
		drain();
		if (retired - ret0 != accepted - acc0) begin
			$display("Mismatch at %0t: %0d ops retired, expected %0d", $time,
				retired - ret0, accepted - acc0);
			errors++;
		end
		check_all_regs();
		report_test("back-pressure mix", mark);

		mark = errors;
		for (int i = 0; i < N_EBRK; i++) begin
			random_op(1'b1);
		end
		drain();
		check_all_regs();
		report_test("ebreak and stores", mark);

		$display("summary: %0d checks matched, %0d mismatched", checks_ok, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
rv_backend_pkg.sv
mem_wb_if.sv
data_mem.sv
mem_stage.sv
mem_wb_regs.sv
wb_stage.sv
reg_file.sv
rv_backend_top.sv
tb_rv_backend.sv
